// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned ALU_OP_W   = 4;

  // ==============================
  // alu operation codes
  // ==============================
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

  // major opcodes handled by this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

  // two views of one instruction word
  // u-type immediate is i.imm, i.rs1 and i.funct3 taken together
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } inst_u;

endpackage

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [rv_pkg::ALU_OP_W-1:0] op_i,
  input  logic [rv_pkg::XLEN-1:0]     a_i,
  input  logic [rv_pkg::XLEN-1:0]     b_i,
  output logic [rv_pkg::XLEN-1:0]     y_o
);
  import rv_pkg::*;

  localparam int unsigned SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  // only the low bits of b count for shifts
  assign shamt       = b_i[SHAMT_W-1:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  y_o = a_i + b_i;
      ALU_SUB:  y_o = a_i - b_i;
      ALU_SLL:  y_o = a_i << shamt;
      ALU_SLT:  y_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: y_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  y_o = a_i ^ b_i;
      ALU_SRL:  y_o = a_i >> shamt;
      ALU_SRA:  y_o = $signed(a_i) >>> shamt;
      ALU_OR:   y_o = a_i | b_i;
      ALU_AND:  y_o = a_i & b_i;
      // unused codes
      default:  y_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
  output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
  input  logic                          wen_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [rv_pkg::XLEN-1:0]       wd_i
);
  import rv_pkg::*;

  localparam int unsigned NUM_REGS = 1 << REG_ADDR_W;

  logic [XLEN-1:0] regs [NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (wen_i && (rd_i != '0)) begin
      regs[rd_i] <= wd_i;
    end
  end

  // a same-cycle write wins over the stored value
  // x0 keeps its reset zero since neither write nor bypass takes rd 0
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
    if (wen_i && (rd_i != '0) && (addr == rd_i)) begin
      return wd_i;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

  x0_reads_zero: assert property (@(posedge clk) disable iff (reset_i)
    ((rs1_i != '0) || (rs1_data_o == '0)) && ((rs2_i != '0) || (rs2_data_o == '0)));

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic [rv_pkg::XLEN-1:0] inst_i,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  output logic [rv_pkg::XLEN-1:0] if_pc_o,
  output logic [rv_pkg::XLEN-1:0] if_inst_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc_q;

  // no redirects, so the pc only ever steps forward
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_q + XLEN'(4);
    end
  end

  assign pc_o = pc_q;

  // ==============================
  // fetch/decode register
  // ==============================
  always_ff @(posedge clk) begin
    if (reset_i) begin
      if_inst_o <= NOP_INST;
    end else begin
      if_inst_o <= inst_i;
    end
  end

  always_ff @(posedge clk) begin
    if_pc_o <= pc_q;
  end

  pc_word_aligned: assert property (@(posedge clk) disable iff (reset_i) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic [rv_pkg::XLEN-1:0]       if_pc_i,
  input  logic [rv_pkg::XLEN-1:0]       if_inst_i,
  input  logic                          wb_wen_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
  input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
  output logic [rv_pkg::XLEN-1:0]       ex_pc_o,
  output logic [rv_pkg::XLEN-1:0]       ex_rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]       ex_rs2_data_o,
  output logic [rv_pkg::XLEN-1:0]       ex_imm_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_o,
  output logic [rv_pkg::ALU_OP_W-1:0]   ex_alu_op_o,
  output logic                          ex_use_imm_o,
  output logic                          ex_op1_pc_o,
  output logic                          ex_op1_zero_o,
  output logic                          ex_wen_o
);
  import rv_pkg::*;

  inst_u                 inst;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_u;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [ALU_OP_W-1:0]   alu_op;
  logic                  use_imm;
  logic                  op1_pc;
  logic                  op1_zero;
  logic                  wen;

  assign inst = if_inst_i;

  // register file reads in decode, writeback bypass lives inside it
  reg_file reg_file_inst (
    .clk       (clk),
    .reset_i   (reset_i),
    .rs1_i     (inst.r.rs1),
    .rs2_i     (inst.r.rs2),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wen_i     (wb_wen_i),
    .rd_i      (wb_rd_i),
    .wd_i      (wb_data_i)
  );

  // immediates
  assign imm_i = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
  assign imm_u = {inst.i.imm, inst.i.rs1, inst.i.funct3, 12'b0};

  // sub only exists in the register group, sra in both
  function automatic logic [ALU_OP_W-1:0] alu_code(input logic [2:0] f3,
                                                  input logic       f7_b5,
                                                  input logic       is_reg);
    case (f3)
      3'b000:  return (is_reg && f7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return f7_b5 ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ==============================
  // control decode
  // ==============================
  always_comb begin
    alu_op   = ALU_ADD;
    use_imm  = 1'b0;
    op1_pc   = 1'b0;
    op1_zero = 1'b0;
    wen      = 1'b0;
    imm      = imm_i;
    case (inst.r.opcode)
      OPC_OP: begin
        wen    = 1'b1;
        alu_op = alu_code(inst.r.funct3, inst.r.funct7[5], 1'b1);
      end
      OPC_OP_IMM: begin
        wen     = 1'b1;
        use_imm = 1'b1;
        alu_op  = alu_code(inst.r.funct3, inst.r.funct7[5], 1'b0);
      end
      OPC_LUI: begin
        wen      = 1'b1;
        use_imm  = 1'b1;
        op1_zero = 1'b1;
        imm      = imm_u;
      end
      OPC_AUIPC: begin
        wen     = 1'b1;
        use_imm = 1'b1;
        op1_pc  = 1'b1;
        imm     = imm_u;
      end
      default: begin
        wen = 1'b0;
      end
    endcase
    // writes to x0 are dropped here
    if (inst.r.rd == '0) begin
      wen = 1'b0;
    end
  end

  // ==============================
  // decode/execute register
  // ==============================
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_wen_o <= 1'b0;
    end else begin
      ex_wen_o <= wen;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc_o       <= if_pc_i;
    ex_rs1_data_o <= rs1_data;
    ex_rs2_data_o <= rs2_data;
    ex_imm_o      <= imm;
    ex_rs1_o      <= inst.r.rs1;
    ex_rs2_o      <= inst.r.rs2;
    ex_rd_o       <= inst.r.rd;
    ex_alu_op_o   <= alu_op;
    ex_use_imm_o  <= use_imm;
    ex_op1_pc_o   <= op1_pc;
    ex_op1_zero_o <= op1_zero;
  end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic [rv_pkg::XLEN-1:0]       ex_pc_i,
  input  logic [rv_pkg::XLEN-1:0]       ex_rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]       ex_rs2_data_i,
  input  logic [rv_pkg::XLEN-1:0]       ex_imm_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  logic [rv_pkg::ALU_OP_W-1:0]   ex_alu_op_i,
  input  logic                          ex_use_imm_i,
  input  logic                          ex_op1_pc_i,
  input  logic                          ex_op1_zero_i,
  input  logic                          ex_wen_i,
  output logic                          wb_wen_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_pkg::XLEN-1:0]       wb_data_o
);
  import rv_pkg::*;

  // memory stage view, kept for forwarding
  logic                  mem_wen;
  logic [REG_ADDR_W-1:0] mem_rd;
  logic [XLEN-1:0]       mem_result;

  logic [XLEN-1:0]       rs1_fwd;
  logic [XLEN-1:0]       rs2_fwd;
  logic [XLEN-1:0]       op1;
  logic [XLEN-1:0]       op2;
  logic [XLEN-1:0]       alu_y;

  // ==============================
  // forwarding
  // ==============================

  // younger producer first. x0 can't match, decode never enables it
  function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] rs,
                                              input logic [XLEN-1:0]       reg_data);
    if (mem_wen && (mem_rd == rs)) begin
      return mem_result;
    end
    if (wb_wen_o && (wb_rd_o == rs)) begin
      return wb_data_o;
    end
    return reg_data;
  endfunction

  always_comb begin
    rs1_fwd = forward(ex_rs1_i, ex_rs1_data_i);
    rs2_fwd = forward(ex_rs2_i, ex_rs2_data_i);
  end

  // operand select: lui takes zero, auipc takes the pc
  always_comb begin
    if (ex_op1_zero_i) begin
      op1 = '0;
    end else if (ex_op1_pc_i) begin
      op1 = ex_pc_i;
    end else begin
      op1 = rs1_fwd;
    end
    op2 = ex_use_imm_i ? ex_imm_i : rs2_fwd;
  end

  alu alu_inst (
    .op_i(ex_alu_op_i),
    .a_i (op1),
    .b_i (op2),
    .y_o (alu_y)
  );

  // ==============================
  // execute/memory register
  // ==============================
  always_ff @(posedge clk) begin
    if (reset_i) begin
      mem_wen <= 1'b0;
    end else begin
      mem_wen <= ex_wen_i;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd     <= ex_rd_i;
    mem_result <= alu_y;
  end

  // ==============================
  // memory/writeback register
  // ==============================
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_wen_o <= 1'b0;
    end else begin
      wb_wen_o <= mem_wen;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o   <= mem_rd;
    wb_data_o <= mem_result;
  end

  // the x0 filter sits three stages back in decode
  wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset_i)
    wb_wen_o |-> (wb_rd_o != '0));

endmodule

`default_nettype wire

// File: verilog/core_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module core_pipeline #(
  parameter  logic [rv_pkg::XLEN-1:0] RESET_PC   = '0,
  localparam int unsigned             XLEN       = rv_pkg::XLEN,
  localparam int unsigned             REG_ADDR_W = rv_pkg::REG_ADDR_W,
  localparam int unsigned             ALU_OP_W   = rv_pkg::ALU_OP_W
) (
  input  logic                  clk,
  input  logic                  reset_i,
  output logic [XLEN-1:0]       pc_o,
  input  logic [XLEN-1:0]       inst_i,
  output logic                  wb_valid_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o
);

  // fetch to decode
  logic [XLEN-1:0]       if_pc;
  logic [XLEN-1:0]       if_inst;

  // decode/execute register outputs
  logic [XLEN-1:0]       ex_pc;
  logic [XLEN-1:0]       ex_rs1_data;
  logic [XLEN-1:0]       ex_rs2_data;
  logic [XLEN-1:0]       ex_imm;
  logic [REG_ADDR_W-1:0] ex_rs1;
  logic [REG_ADDR_W-1:0] ex_rs2;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [ALU_OP_W-1:0]   ex_alu_op;
  logic                  ex_use_imm;
  logic                  ex_op1_pc;
  logic                  ex_op1_zero;
  logic                  ex_wen;

  // writeback, back into the register file and out
  logic                  wb_wen;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  fetch_unit #(
    .RESET_PC(RESET_PC)
  ) fetch_inst (
    .clk      (clk),
    .reset_i  (reset_i),
    .inst_i   (inst_i),
    .pc_o     (pc_o),
    .if_pc_o  (if_pc),
    .if_inst_o(if_inst)
  );

  decode_stage decode_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .if_pc_i      (if_pc),
    .if_inst_i    (if_inst),
    .wb_wen_i     (wb_wen),
    .wb_rd_i      (wb_rd),
    .wb_data_i    (wb_data),
    .ex_pc_o      (ex_pc),
    .ex_rs1_data_o(ex_rs1_data),
    .ex_rs2_data_o(ex_rs2_data),
    .ex_imm_o     (ex_imm),
    .ex_rs1_o     (ex_rs1),
    .ex_rs2_o     (ex_rs2),
    .ex_rd_o      (ex_rd),
    .ex_alu_op_o  (ex_alu_op),
    .ex_use_imm_o (ex_use_imm),
    .ex_op1_pc_o  (ex_op1_pc),
    .ex_op1_zero_o(ex_op1_zero),
    .ex_wen_o     (ex_wen)
  );

  execute_stage execute_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .ex_pc_i      (ex_pc),
    .ex_rs1_data_i(ex_rs1_data),
    .ex_rs2_data_i(ex_rs2_data),
    .ex_imm_i     (ex_imm),
    .ex_rs1_i     (ex_rs1),
    .ex_rs2_i     (ex_rs2),
    .ex_rd_i      (ex_rd),
    .ex_alu_op_i  (ex_alu_op),
    .ex_use_imm_i (ex_use_imm),
    .ex_op1_pc_i  (ex_op1_pc),
    .ex_op1_zero_i(ex_op1_zero),
    .ex_wen_i     (ex_wen),
    .wb_wen_o     (wb_wen),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  assign wb_valid_o = wb_wen;
  assign wb_rd_o    = wb_rd;
  assign wb_data_o  = wb_data;

endmodule

`default_nettype wire

// File: testbench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int HALF_PERIOD_NS = 2,
  parameter int RESET_CYCLES   = 4
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/tb_core_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_pipeline;
  import rv_pkg::*;

  logic                  clk;
  logic                  reset_i;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       inst;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  // instruction table with one row per word address
  logic [XLEN-1:0]       tbl_inst[$];
  logic                  tbl_wr[$];
  logic [REG_ADDR_W-1:0] tbl_rd[$];
  logic [XLEN-1:0]       tbl_val[$];

  // rows still waiting for their writeback
  int exp_idx[$];

  int cyc = 0;
  int ticks = 0;
  int limit;
  int errors = 0;
  int checks = 0;
  int seed;

  clock_gen clock_gen_inst (
    .clk_o  (clk),
    .reset_o(reset_i)
  );

  core_pipeline #(
    .RESET_PC(32'h0000_0000)
  ) dut (
    .clk       (clk),
    .reset_i   (reset_i),
    .pc_o      (pc),
    .inst_i    (inst),
    .wb_valid_o(wb_valid),
    .wb_rd_o   (wb_rd),
    .wb_data_o (wb_data)
  );

  // cycles since reset release, equal to the word index being fetched
  always @(posedge clk) begin
    ticks <= ticks + 1;
    if (!reset_i) begin
      cyc <= cyc + 1;
    end
  end

  // ==============================
  // encoders and table
  // ==============================
  function automatic logic [XLEN-1:0] op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [XLEN-1:0] op_imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                  input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [XLEN-1:0] upper_word(input logic [19:0] imm, input logic [4:0] rd,
                                                 input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [XLEN-1:0] sign_extend12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  task automatic add_row(input logic [XLEN-1:0] word, input logic wr,
                         input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] val);
    tbl_inst.push_back(word);
    tbl_wr.push_back(wr);
    tbl_rd.push_back(rd);
    tbl_val.push_back(val);
  endtask

  task automatic build_table();
    logic [31:0]     rnd;
    logic [11:0]     rimm[4];
    logic [XLEN-1:0] v_add;
    logic [XLEN-1:0] v_xor;
    logic [XLEN-1:0] v_and;
    logic [XLEN-1:0] v_slt;
    // sources, then add sub sll slt sltu xor srl sra or and, then swapped compares
    add_row(op_imm_word(12'hFF9, 5'd0, 3'h0, 5'd1), 1'b1, 5'd1, 32'hFFFF_FFF9);
    add_row(op_imm_word(12'h005, 5'd0, 3'h0, 5'd2), 1'b1, 5'd2, 32'h0000_0005);
    add_row(op_imm_word(12'h123, 5'd0, 3'h0, 5'd3), 1'b1, 5'd3, 32'h0000_0123);
    add_row(op_imm_word(12'hFFF, 5'd0, 3'h0, 5'd4), 1'b1, 5'd4, 32'hFFFF_FFFF);
    add_row(op_word(7'h00, 5'd2, 5'd1, 3'h0, 5'd5), 1'b1, 5'd5, 32'hFFFF_FFFE);
    add_row(op_word(7'h20, 5'd1, 5'd2, 3'h0, 5'd6), 1'b1, 5'd6, 32'h0000_000C);
    add_row(op_word(7'h00, 5'd2, 5'd3, 3'h1, 5'd7), 1'b1, 5'd7, 32'h0000_2460);
    add_row(op_word(7'h00, 5'd2, 5'd1, 3'h2, 5'd8), 1'b1, 5'd8, 32'h0000_0001);
    add_row(op_word(7'h00, 5'd2, 5'd1, 3'h3, 5'd9), 1'b1, 5'd9, 32'h0000_0000);
    add_row(op_word(7'h00, 5'd4, 5'd3, 3'h4, 5'd10), 1'b1, 5'd10, 32'hFFFF_FEDC);
    add_row(op_word(7'h00, 5'd2, 5'd1, 3'h5, 5'd11), 1'b1, 5'd11, 32'h07FF_FFFF);
    add_row(op_word(7'h20, 5'd2, 5'd1, 3'h5, 5'd12), 1'b1, 5'd12, 32'hFFFF_FFFF);
    add_row(op_word(7'h00, 5'd2, 5'd3, 3'h6, 5'd13), 1'b1, 5'd13, 32'h0000_0127);
    add_row(op_word(7'h00, 5'd4, 5'd3, 3'h7, 5'd14), 1'b1, 5'd14, 32'h0000_0123);
    add_row(op_word(7'h00, 5'd1, 5'd2, 3'h2, 5'd15), 1'b1, 5'd15, 32'h0000_0000);
    add_row(op_word(7'h00, 5'd1, 5'd2, 3'h3, 5'd16), 1'b1, 5'd16, 32'h0000_0001);
    // immediates and shifts by immediate, then lui at word 25 and auipc at 26 and 27
    add_row(op_imm_word(12'h800, 5'd2, 3'h0, 5'd17), 1'b1, 5'd17, 32'hFFFF_F805);
    add_row(op_imm_word(12'hFFA, 5'd1, 3'h2, 5'd18), 1'b1, 5'd18, 32'h0000_0001);
    add_row(op_imm_word(12'hFFF, 5'd2, 3'h3, 5'd19), 1'b1, 5'd19, 32'h0000_0001);
    add_row(op_imm_word(12'hFFF, 5'd3, 3'h4, 5'd20), 1'b1, 5'd20, 32'hFFFF_FEDC);
    add_row(op_imm_word(12'h700, 5'd2, 3'h6, 5'd21), 1'b1, 5'd21, 32'h0000_0705);
    add_row(op_imm_word(12'h0F0, 5'd4, 3'h7, 5'd22), 1'b1, 5'd22, 32'h0000_00F0);
    add_row(op_imm_word(12'h01F, 5'd2, 3'h1, 5'd23), 1'b1, 5'd23, 32'h8000_0000);
    add_row(op_imm_word(12'h01C, 5'd4, 3'h5, 5'd24), 1'b1, 5'd24, 32'h0000_000F);
    add_row(op_imm_word(12'h401, 5'd1, 3'h5, 5'd25), 1'b1, 5'd25, 32'hFFFF_FFFC);
    add_row(upper_word(20'hABCDE, 5'd26, 7'b0110111), 1'b1, 5'd26, 32'hABCD_E000);
    add_row(upper_word(20'h12345, 5'd27, 7'b0010111), 1'b1, 5'd27, 32'h1234_5068);
    add_row(upper_word(20'hFFFFF, 5'd28, 7'b0010111), 1'b1, 5'd28, 32'hFFFF_F06C);
    // producer/consumer chains at distance 1, 2 and 3
    add_row(op_imm_word(12'h064, 5'd0, 3'h0, 5'd5), 1'b1, 5'd5, 32'h0000_0064);
    add_row(op_word(7'h00, 5'd5, 5'd5, 3'h0, 5'd6), 1'b1, 5'd6, 32'h0000_00C8);
    add_row(op_word(7'h20, 5'd5, 5'd6, 3'h0, 5'd7), 1'b1, 5'd7, 32'h0000_0064);
    add_row(op_word(7'h00, 5'd7, 5'd5, 3'h0, 5'd8), 1'b1, 5'd8, 32'h0000_00C8);
    add_row(op_imm_word(12'h001, 5'd6, 3'h0, 5'd9), 1'b1, 5'd9, 32'h0000_00C9);
    add_row(op_word(7'h00, 5'd7, 5'd8, 3'h4, 5'd10), 1'b1, 5'd10, 32'h0000_00AC);
    // the younger of two x11 producers in flight must win
    add_row(op_imm_word(12'h001, 5'd0, 3'h0, 5'd11), 1'b1, 5'd11, 32'h0000_0001);
    add_row(op_imm_word(12'h002, 5'd11, 3'h0, 5'd11), 1'b1, 5'd11, 32'h0000_0003);
    add_row(op_imm_word(12'h004, 5'd11, 3'h0, 5'd11), 1'b1, 5'd11, 32'h0000_0007);
    add_row(op_word(7'h00, 5'd11, 5'd11, 3'h0, 5'd12), 1'b1, 5'd12, 32'h0000_000E);
    // x0 target, lw x5 and jal x1 which this core ignores
    add_row(op_imm_word(12'h037, 5'd1, 3'h0, 5'd0), 1'b0, 5'd0, 32'h0);
    add_row(32'h0000_2283, 1'b0, 5'd0, 32'h0);
    add_row(32'h0000_00EF, 1'b0, 5'd0, 32'h0);
    // x0 read right behind an x0 write
    add_row(op_word(7'h00, 5'd3, 5'd2, 3'h0, 5'd0), 1'b0, 5'd0, 32'h0);
    add_row(op_word(7'h00, 5'd0, 5'd0, 3'h0, 5'd13), 1'b1, 5'd13, 32'h0000_0000);
    add_row(op_word(7'h00, 5'd2, 5'd0, 3'h6, 5'd15), 1'b1, 5'd15, 32'h0000_0005);
    // random immediates with results from the isa rules
    seed = 26210;
    for (int k = 0; k < 4; k++) begin
      rnd = $random(seed);
      rimm[k] = rnd[11:0];
    end
    v_add = sign_extend12(rimm[0]);
    v_xor = v_add ^ sign_extend12(rimm[1]);
    v_and = v_xor & sign_extend12(rimm[2]);
    v_slt = ($signed(v_add) < $signed(sign_extend12(rimm[3]))) ? 32'd1 : 32'd0;
    add_row(op_imm_word(rimm[0], 5'd0, 3'h0, 5'd16), 1'b1, 5'd16, v_add);
    add_row(op_imm_word(rimm[1], 5'd16, 3'h4, 5'd17), 1'b1, 5'd17, v_xor);
    add_row(op_imm_word(rimm[2], 5'd17, 3'h7, 5'd18), 1'b1, 5'd18, v_and);
    add_row(op_imm_word(rimm[3], 5'd16, 3'h2, 5'd19), 1'b1, 5'd19, v_slt);
  endtask

  // ==============================
  // checks
  // ==============================
  task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want,
                            input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: %s expected %h got %h", $time, what, want, got);
    end
  endtask

  task automatic check_reg_addr(input logic [REG_ADDR_W-1:0] got,
                                input logic [REG_ADDR_W-1:0] want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: %s expected x%0d got x%0d", $time, what, want, got);
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: %s expected %b got %b", $time, what, want, got);
    end
  endtask

  // a write is due exactly 4 cycles after its row was fetched
  task automatic check_writeback();
    int   row;
    logic want;
    want = 1'b0;
    row = -1;
    if (exp_idx.size() != 0) begin
      if (cyc == exp_idx[0] + 4) begin
        want = 1'b1;
        row = exp_idx.pop_front();
      end
    end
    check_flag(wb_valid, want, $sformatf("writeback valid in cycle %0d", cyc));
    if (want && (wb_valid === 1'b1)) begin
      check_reg_addr(wb_rd, tbl_rd[row], $sformatf("rd of row %0d", row));
      check_word(wb_data, tbl_val[row], $sformatf("data of row %0d", row));
    end
  endtask

  task automatic drive_fetch();
    int idx;
    idx = int'(pc[XLEN-1:2]);
    if (idx < tbl_inst.size()) begin
      inst = tbl_inst[idx];
    end else begin
      inst = NOP_INST;
    end
  endtask

  initial begin
    inst = NOP_INST;
    build_table();
    for (int k = 0; k < tbl_inst.size(); k++) begin
      if (tbl_wr[k]) begin
        exp_idx.push_back(k);
      end
    end
    @(posedge clk);
    while (cyc < tbl_inst.size() + 6) begin
      @(negedge clk);
      check_word(pc, XLEN'(cyc * 4), "fetch address");
      drive_fetch();
      check_writeback();
    end
    if (exp_idx.size() != 0) begin
      errors++;
      $display("%0d expected writes never arrived", exp_idx.size());
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // table, pipeline depth, reset and some slack
  initial begin
    @(posedge clk);
    limit = tbl_inst.size() + 4 + 4 + 20;
    wait (ticks >= limit);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("checks run: %0d, errors: %0d", checks, errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
verilog/rv_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/core_pipeline.sv
testbench/clock_gen.sv
testbench/tb_core_pipeline.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_core_pipeline -Mdir obj_dir -f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_output="$(./obj_dir/Vtb_core_pipeline)"
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "=== PASS ==="; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi
